// ==== design/alu.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module alu (
    input  logic [`RV_XLEN-1:0] op_a,
    input  logic [`RV_XLEN-1:0] op_b,
    input  rv_pkg::alu_op_t     alu_op,
    output logic [`RV_XLEN-1:0] result,
    output logic                branch_true
);

    logic signed [`RV_XLEN-1:0] op_a_s;
    logic signed [`RV_XLEN-1:0] op_b_s;
    logic [4:0]                 shamt;

    assign op_a_s = op_a;
    assign op_b_s = op_b;
    assign shamt  = op_b[4:0];

    always_comb begin
        result      = '0;
        branch_true = 1'b0;

        case (alu_op)
            rv_pkg::ALU_ADD:  result = op_a + op_b;
            rv_pkg::ALU_SUB:  result = op_a - op_b;
            rv_pkg::ALU_AND:  result = op_a & op_b;
            rv_pkg::ALU_OR:   result = op_a | op_b;
            rv_pkg::ALU_XOR:  result = op_a ^ op_b;
            rv_pkg::ALU_SLL:  result = op_a << shamt;
            rv_pkg::ALU_SRL:  result = op_a >> shamt;
            rv_pkg::ALU_SRA:  result = op_a_s >>> shamt;
            rv_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, op_a_s < op_b_s};
            rv_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};

            // Branch compares leave result at zero
            rv_pkg::ALU_BEQ:  branch_true = (op_a == op_b);
            rv_pkg::ALU_BNE:  branch_true = (op_a != op_b);
            rv_pkg::ALU_BLT:  branch_true = (op_a_s < op_b_s);
            rv_pkg::ALU_BGE:  branch_true = (op_a_s >= op_b_s);
            rv_pkg::ALU_BLTU: branch_true = (op_a < op_b);
            rv_pkg::ALU_BGEU: branch_true = (op_a >= op_b);
            default: ;
        endcase
    end

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module decoder (
    input  logic [31:0]     instr,
    output rv_pkg::alu_op_t alu_op,
    output logic            reg_write,
    output logic            alu_src,
    output logic            mem_read,
    output logic            mem_write,
    output logic            branch,
    output logic            jump,
    output logic            jump_reg,
    output logic            use_zero_rs1,
    output rv_pkg::wb_src_t wb_src
);

    rv_pkg::opcode_t           opcode;
    logic [2:0]                funct3;
    logic                      funct7_b5;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic                      rd_write;

    assign opcode    = rv_pkg::opcode_t'(instr[`RV_OPCODE_W-1:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];     // SUB and SRA select
    assign rd        = instr[11:7];

    // A write to x0 has no effect, so drop it here
    assign reg_write = rd_write && (rd != '0);

    always_comb begin
        alu_op       = rv_pkg::ALU_ADD;
        rd_write     = 1'b0;
        alu_src      = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        branch       = 1'b0;
        jump         = 1'b0;
        jump_reg     = 1'b0;
        use_zero_rs1 = 1'b0;
        wb_src       = rv_pkg::WB_ALU;

        case (opcode)
            rv_pkg::OP_REG, rv_pkg::OP_IMM: begin
                rd_write = 1'b1;
                alu_src  = (opcode == rv_pkg::OP_IMM);
                case (funct3)
                    3'b000: alu_op = (opcode == rv_pkg::OP_REG && funct7_b5) ?
                                     rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: alu_op = rv_pkg::ALU_SLL;
                    3'b010: alu_op = rv_pkg::ALU_SLT;
                    3'b011: alu_op = rv_pkg::ALU_SLTU;
                    3'b100: alu_op = rv_pkg::ALU_XOR;
                    3'b101: alu_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: alu_op = rv_pkg::ALU_OR;
                    default: alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OP_LOAD: begin
                rd_write = 1'b1;
                alu_src  = 1'b1;      // Address is rs1 + imm
                mem_read = 1'b1;
                wb_src   = rv_pkg::WB_MEM;
            end
            rv_pkg::OP_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                branch = 1'b1;
                case (funct3)
                    3'b000: alu_op = rv_pkg::ALU_BEQ;
                    3'b001: alu_op = rv_pkg::ALU_BNE;
                    3'b100: alu_op = rv_pkg::ALU_BLT;
                    3'b101: alu_op = rv_pkg::ALU_BGE;
                    3'b110: alu_op = rv_pkg::ALU_BLTU;
                    3'b111: alu_op = rv_pkg::ALU_BGEU;
                    default: alu_op = rv_pkg::ALU_ADD;   // Never taken
                endcase
            end
            rv_pkg::OP_JAL: begin
                rd_write = 1'b1;
                jump     = 1'b1;
                wb_src   = rv_pkg::WB_PC4;
            end
            rv_pkg::OP_JALR: begin
                rd_write = 1'b1;
                alu_src  = 1'b1;
                jump     = 1'b1;
                jump_reg = 1'b1;      // Target from the ALU sum
                wb_src   = rv_pkg::WB_PC4;
            end
            rv_pkg::OP_LUI: begin
                rd_write     = 1'b1;
                alu_src      = 1'b1;
                use_zero_rs1 = 1'b1;  // 0 + upper immediate
            end
            default: ;                // Unknown opcode runs as a no-op
        endcase
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                take_branch,
    input  logic [`RV_XLEN-1:0] target,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] pc_plus4
);

    logic [`RV_XLEN-1:0] pc_next;

    assign pc_plus4 = pc + `RV_XLEN'd4;

    // Hold while the LSU owns the cycle, else redirect or fall through
    always_comb begin
        if (stall) begin
            pc_next = pc;
        end else if (take_branch) begin
            pc_next = target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Branch and JALR targets must keep fetch on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== design/imm_gen.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module imm_gen (
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] imm
);

    rv_pkg::opcode_t opcode;
    logic            sign;

    assign opcode = rv_pkg::opcode_t'(instr[`RV_OPCODE_W-1:0]);
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            // I format
            rv_pkg::OP_IMM, rv_pkg::OP_LOAD, rv_pkg::OP_JALR: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            rv_pkg::OP_STORE: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::OP_BRANCH: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::OP_JAL: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            rv_pkg::OP_LUI: begin
                imm = {instr[31:12], 12'b0};
            end
            default: begin
                imm = '0;             // R format and anything unknown
            end
        endcase
    end

endmodule

// ==== design/lsu_wb.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module lsu_wb (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic                stall,
    output logic [`RV_XLEN-1:0] load_data,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`RV_XLEN-1:0] wb_adr,
    output logic [`RV_XLEN-1:0] wb_dat_o,
    input  logic [`RV_XLEN-1:0] wb_dat_i,
    input  logic                wb_ack
);

    rv_pkg::lsu_state_t  state;
    rv_pkg::lsu_state_t  state_nxt;
    logic                start;
    logic                we_q;
    logic [`RV_XLEN-1:0] adr_q;
    logic [`RV_XLEN-1:0] dat_q;
    logic [`RV_XLEN-1:0] rdata_q;

    assign start = (state == rv_pkg::LSU_IDLE) && (mem_read || mem_write);

    // Core waits from decode until the DONE cycle
    assign stall = start || (state == rv_pkg::LSU_WAIT);

    always_comb begin
        case (state)
            rv_pkg::LSU_IDLE: state_nxt = start ? rv_pkg::LSU_WAIT : rv_pkg::LSU_IDLE;
            rv_pkg::LSU_WAIT: state_nxt = wb_ack ? rv_pkg::LSU_DONE : rv_pkg::LSU_WAIT;
            default:          state_nxt = rv_pkg::LSU_IDLE;   // DONE always returns
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rv_pkg::LSU_IDLE;
            we_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) we_q <= mem_write;
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= addr;
            dat_q <= wdata;
        end
        if (state == rv_pkg::LSU_WAIT && wb_ack) rdata_q <= wb_dat_i;
    end

    assign wb_cyc    = (state == rv_pkg::LSU_WAIT);
    assign wb_stb    = wb_cyc;
    assign wb_we     = wb_cyc && we_q;
    assign wb_adr    = adr_q;
    assign wb_dat_o  = dat_q;
    assign load_data = rdata_q;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

    // Wishbone classic: request frozen until acked
    a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack) |=> wb_cyc && $stable(wb_adr) && $stable(wb_dat_o)
                                && $stable(wb_we));

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1,
    input  logic [`RV_REG_ADDR_W-1:0] rs2,
    input  logic [`RV_REG_ADDR_W-1:0] rd,
    input  logic [`RV_XLEN-1:0]       wdata,
    input  logic                      we,
    output logic [`RV_XLEN-1:0]       rdata1,
    output logic [`RV_XLEN-1:0]       rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Combinational reads, x0 is never written so it stays zero
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 must survive any write sequence
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1 == '0 |-> rdata1 == '0) and (rs2 == '0 |-> rdata2 == '0));

endmodule

// ==== design/riscv_core.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module riscv_core (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [31:0]         imem_data,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`RV_XLEN-1:0] wb_adr,
    output logic [`RV_XLEN-1:0] wb_dat_o,
    input  logic [`RV_XLEN-1:0] wb_dat_i,
    input  logic                wb_ack
);

    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       pc_plus4;
    logic [`RV_XLEN-1:0]       target;
    logic                      take_branch;
    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_REG_ADDR_W-1:0] rd_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       rd_wdata;
    logic                      rf_we;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_XLEN-1:0]       op_a;
    logic [`RV_XLEN-1:0]       op_b;
    logic [`RV_XLEN-1:0]       alu_result;
    logic                      branch_true;
    rv_pkg::alu_op_t           alu_op;
    rv_pkg::wb_src_t           wb_src;
    logic                      reg_write;
    logic                      alu_src;
    logic                      mem_read;
    logic                      mem_write;
    logic                      branch;
    logic                      jump;
    logic                      jump_reg;
    logic                      use_zero_rs1;
    logic                      stall;
    logic [`RV_XLEN-1:0]       load_data;

    assign imem_addr = pc;
    assign rs1_addr  = imem_data[19:15];
    assign rs2_addr  = imem_data[24:20];
    assign rd_addr   = imem_data[11:7];

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .stall(stall), .take_branch(take_branch),
        .target(target), .pc(pc), .pc_plus4(pc_plus4)
    );

    decoder u_dec (
        .instr(imem_data), .alu_op(alu_op), .reg_write(reg_write), .alu_src(alu_src),
        .mem_read(mem_read), .mem_write(mem_write), .branch(branch), .jump(jump),
        .jump_reg(jump_reg), .use_zero_rs1(use_zero_rs1), .wb_src(wb_src)
    );

    imm_gen u_imm (.instr(imem_data), .imm(imm));

    reg_file u_rf (
        .clk(clk), .rst(rst), .rs1(rs1_addr), .rs2(rs2_addr), .rd(rd_addr),
        .wdata(rd_wdata), .we(rf_we), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    // Operand muxes, LUI adds its immediate to zero
    assign op_a = use_zero_rs1 ? '0 : rs1_data;
    assign op_b = alu_src ? imm : rs2_data;

    alu u_alu (
        .op_a(op_a), .op_b(op_b), .alu_op(alu_op),
        .result(alu_result), .branch_true(branch_true)
    );

    // JALR clears bit 0 of rs1 + imm
    assign take_branch = (branch && branch_true) || jump;
    assign target      = jump_reg ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc + imm;

    lsu_wb u_lsu (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
        .addr(alu_result), .wdata(rs2_data), .stall(stall), .load_data(load_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always_comb begin
        case (wb_src)
            rv_pkg::WB_MEM: rd_wdata = load_data;
            rv_pkg::WB_PC4: rd_wdata = pc_plus4;
            default:        rd_wdata = alu_result;
        endcase
    end

    assign rf_we = reg_write && !stall;   // Loads write only in LSU_DONE

    // No register retires while a bus cycle is open
    a_no_wr_in_bus: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> !rf_we);

endmodule

// ==== design/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Base integer ISA widths
`define RV_XLEN        32
`define RV_OPCODE_W    7    // instr[6:0]

// Integer register file
`define RV_REG_COUNT   32
`define RV_REG_ADDR_W  5

// First fetch address after reset
`define RV_RESET_PC    32'h0000_0000

`endif

// ==== design/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

    // Major opcodes handled by the core
    typedef enum logic [`RV_OPCODE_W-1:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111
    } opcode_t;

    // ALU and branch compare operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLL  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SRA  = 4'b0111,
        ALU_SLT  = 4'b1000,
        ALU_SLTU = 4'b1001,
        ALU_BEQ  = 4'b1010,   // Compare only, result unused
        ALU_BNE  = 4'b1011,
        ALU_BLT  = 4'b1100,
        ALU_BGE  = 4'b1101,
        ALU_BLTU = 4'b1110,
        ALU_BGEU = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2        // Link value for JAL and JALR
    } wb_src_t;

    // Load/store bus sequencer
    typedef enum logic [1:0] {
        LSU_IDLE = 2'd0,
        LSU_WAIT = 2'd1,
        LSU_DONE = 2'd2
    } lsu_state_t;

endpackage

// ==== filelist.f ====
+incdir+design
design/rv_pkg.sv
design/fetch_unit.sv
design/decoder.sv
design/imm_gen.sv
design/alu.sv
design/reg_file.sv
design/lsu_wb.sv
design/riscv_core.sv
tests/wb_mem_model.sv
tests/tb_riscv_core.sv

// ==== tests/tb_riscv_core.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module tb_riscv_core;

    localparam logic [6:0] op_imm  = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam int watchdog_ns     = 5 * 200 * 6 * 10;   // Tests x instrs x cycles x period

    logic                clk;
    logic                rst;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [31:0]         imem_data;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [`RV_XLEN-1:0] wb_adr;
    logic [`RV_XLEN-1:0] wb_dat_o;
    logic [`RV_XLEN-1:0] wb_dat_i;
    logic                wb_ack;
    logic [31:0]         rom [256];
    logic [255:0]        fetched;
    logic                misaligned;   // Any fetch off a word boundary
    int                  n_words;
    int                  errors;
    int                  tests_run;
    integer              seed = 32'h0ce8_45d3;

    assign imem_data = rom[imem_addr[31:2]];

    riscv_core u_dut (.*);

    wb_mem_model u_mem (
        .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_i(wb_dat_o), .dat_o(wb_dat_i), .ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Word addresses fetched since reset
    always @(posedge clk) begin
        if (rst) begin
            fetched    <= '0;
            misaligned <= 1'b0;
        end else begin
            fetched[imem_addr[9:2]] <= 1'b1;
            if (imem_addr[1:0] != 2'b00) misaligned <= 1'b1;
        end
    end

    // Instruction encoders
    function automatic [31:0] r_type(input [2:0] f3, input alt, input [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction
    function automatic [31:0] i_type(input [11:0] imm, input [4:0] rs1, input [2:0] f3,
                                     input [4:0] rd, input [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction
    function automatic [31:0] s_word(input [11:0] imm, input [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction
    function automatic [31:0] b_type(input [12:0] off, input [2:0] f3, input [4:0] rs1, rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction
    function automatic [31:0] j_type(input [20:0] off, input [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction
    function automatic [31:0] u_type(input [19:0] up, input [4:0] rd);
        return {up, rd, 7'b0110111};
    endfunction

    // RV32I reference results by funct3
    function automatic [31:0] ref_alu(input [2:0] f3, input alt, input [31:0] x, y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'b0, $signed(x) < $signed(y)};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt) begin
                    return $signed(x) >>> y[4:0];
                end else begin
                    return x >> y[4:0];
                end
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction
    function automatic bit ref_branch(input [2:0] f3, input [31:0] x, y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return $signed(x) < $signed(y);
            3'd5: return $signed(x) >= $signed(y);
            3'd6: return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic emit(input [31:0] word);
        rom[n_words] = word;
        n_words++;
    endtask

    task automatic put_const(input [4:0] rd, input [31:0] value);
        emit(u_type(value[31:12] + value[11], rd));   // Carry for negative low part
        emit(i_type(value[11:0], rd, 3'd0, rd, op_imm));
    endtask

    // Holds the core in reset while a new program is written
    // Called at time 0 or right after a falling edge
    task automatic start_program();
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = i_type(i * 4, 5'd0, 3'd0, 5'd0, op_imm);   // No-op tagged with its address
        end
        n_words = 0;
    endtask

    task automatic check_idle(input string when);
        if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || wb_we !== 1'b0) begin
            report_fail($sformatf("bus not idle %s", when));
        end
        if (imem_addr !== `RV_RESET_PC) begin
            report_fail($sformatf("imem_addr %h %s, expected reset PC", imem_addr, when));
        end
    endtask

    task automatic run_program();
        emit(s_word(12'hffc, 5'd0, 5'd0));   // End marker store
        emit(j_type(21'd0, 5'd0));
        repeat (3) @(negedge clk);
        check_idle("during reset");
        rst = 1'b0;
        #2;
        check_idle("in the first cycle after reset");
        while (!u_mem.end_seen) @(negedge clk);
        tests_run++;
    endtask

    task automatic expect_word(input [31:0] adr, input [31:0] exp, input string what);
        if (!u_mem.written[adr[11:2]]) begin
            report_fail($sformatf("%s: no store reached address %h", what, adr));
        end else if (u_mem.mem[adr[11:2]] !== exp) begin
            report_fail($sformatf("%s: address %h holds %h, expected %h",
                                  what, adr, u_mem.mem[adr[11:2]], exp));
        end
    endtask

    task automatic expect_untouched(input [31:0] adr, input string what);
        if (u_mem.written[adr[11:2]]) begin
            report_fail($sformatf("%s: skipped store wrote address %h", what, adr));
        end
    endtask

    task automatic test_alu_ops();
        logic [2:0]  f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        bit          alts [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        logic [31:0] a = 32'h8765_4321;
        logic [31:0] b = 32'hffff_fff3;
        logic [11:0] imm;
        start_program();
        put_const(5'd1, a);
        put_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(r_type(f3s[k], alts[k], 5'd3, 5'd1, 5'd2));
            emit(s_word(12'h100 + 4 * k, 5'd3, 5'd0));
        end
        for (int k = 0; k < 10; k++) begin
            if (k == 1) continue;   // No SUBI
            imm = (f3s[k] == 3'd1 || f3s[k] == 3'd5) ? {1'b0, alts[k], 10'd7} : 12'hed4;
            emit(i_type(imm, 5'd1, f3s[k], 5'd4, op_imm));
            emit(s_word(12'h180 + 4 * k, 5'd4, 5'd0));
        end
        run_program();
        for (int k = 0; k < 10; k++) begin
            expect_word(32'h100 + 4 * k, ref_alu(f3s[k], alts[k], a, b), "R-type op");
            if (k == 1) continue;
            expect_word(32'h180 + 4 * k, ref_alu(f3s[k], alts[k], a,
                (f3s[k] == 3'd1 || f3s[k] == 3'd5) ? 32'd7 : 32'hffff_fed4), "I-type op");
        end
    endtask

    task automatic test_branches();
        logic [2:0]  kinds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [31:0] vals [3] = '{32'd0, 32'hffff_fffb, 32'd3};
        logic [4:0]  ras [12];
        logic [4:0]  rbs [12];
        logic [31:0] base;
        start_program();
        emit(i_type(12'hffb, 5'd0, 3'd0, 5'd1, op_imm));   // x1 = -5
        emit(i_type(12'h003, 5'd0, 3'd0, 5'd2, op_imm));
        emit(i_type(12'h0aa, 5'd0, 3'd0, 5'd6, op_imm));   // Fall-through marker
        emit(i_type(12'h0bb, 5'd0, 3'd0, 5'd7, op_imm));   // Taken marker
        for (int c = 0; c < 12; c++) begin
            ras[c] = (c % 2 == 1 && kinds[c / 2] >= 3'd4) ? 5'd2 : 5'd1;
            rbs[c] = (c % 2 == 0) ? 5'd2 : 5'd1;
            base = 32'h200 + 8 * c;
            emit(b_type(13'd12, kinds[c / 2], ras[c], rbs[c]));
            emit(s_word(base[11:0], 5'd6, 5'd0));
            emit(j_type(21'd8, 5'd0));
            emit(s_word(base[11:0] + 12'd4, 5'd7, 5'd0));
        end
        run_program();
        for (int c = 0; c < 12; c++) begin
            base = 32'h200 + 8 * c;
            if (ref_branch(kinds[c / 2], vals[ras[c]], vals[rbs[c]])) begin
                expect_word(base + 4, 32'h0bb, "taken branch");
                expect_untouched(base, "taken branch");
            end else begin
                expect_word(base, 32'h0aa, "branch not taken");
                expect_untouched(base + 4, "branch not taken");
            end
        end
    endtask

    task automatic test_jumps();
        logic [31:0] jalr_tgt = (32'd33 + 32'd4) & ~32'd1;
        start_program();
        emit(j_type(21'd12, 5'd1));                       // 0x00
        emit(s_word(12'h304, 5'd0, 5'd0));
        emit(s_word(12'h308, 5'd0, 5'd0));
        emit(s_word(12'h300, 5'd1, 5'd0));                // 0x0c
        emit(i_type(12'd33, 5'd0, 3'd0, 5'd2, op_imm));
        emit(i_type(12'd4, 5'd2, 3'd0, 5'd3, op_jalr));   // 0x14 with an odd sum
        for (int k = 0; k < 3; k++) emit(s_word(12'h30c + 4 * k, 5'd0, 5'd0));
        emit(s_word(12'h318, 5'd3, 5'd0));                // 0x24
        run_program();
        expect_word(32'h300, 32'h00 + 4, "JAL link");
        expect_word(32'h318, 32'h14 + 4, "JALR link");
        for (int k = 0; k < 5; k++) expect_untouched(32'h304 + 4 * k, "jumped-over store");
        if (fetched[1] || fetched[2] || fetched[6] || fetched[7] || fetched[8]) begin
            report_fail("a jumped-over word was fetched");
        end
        if (!fetched[3] || !fetched[jalr_tgt[9:2]]) begin
            report_fail("a jump target was never fetched");
        end
        if (misaligned) begin
            report_fail("a fetch address was not word aligned");
        end
    endtask

    task automatic test_load_store();
        logic [31:0] w [4];
        logic [31:0] sum = '0;
        start_program();
        for (int k = 0; k < 4; k++) begin
            w[k] = $random(seed);
            sum += w[k];
            put_const(5'd10 + k, w[k]);
            emit(s_word(12'h400 + 4 * k, 5'd10 + k, 5'd0));
        end
        for (int k = 0; k < 4; k++) begin
            emit(i_type(12'h400 + 4 * k, 5'd0, 3'b010, 5'd20 + k, op_load));
        end
        emit(r_type(3'd0, 1'b0, 5'd5, 5'd20, 5'd21));
        emit(r_type(3'd0, 1'b0, 5'd5, 5'd5, 5'd22));
        emit(r_type(3'd0, 1'b0, 5'd5, 5'd5, 5'd23));
        emit(s_word(12'h420, 5'd5, 5'd0));
        run_program();
        for (int k = 0; k < 4; k++) expect_word(32'h400 + 4 * k, w[k], "stored word");
        expect_word(32'h420, sum, "sum of loaded words");
        if (u_mem.n_cyc != 10 || u_mem.n_ack != 10) begin
            report_fail($sformatf("%0d bus cycles with %0d acks, expected 10 of each",
                                  u_mem.n_cyc, u_mem.n_ack));
        end
        if (u_mem.n_unstable != 0) report_fail("address or data changed while cyc was high");
    endtask

    task automatic test_x0();
        start_program();
        emit(i_type(12'h055, 5'd0, 3'd0, 5'd0, op_imm));
        emit(s_word(12'h500, 5'd0, 5'd0));
        run_program();
        expect_word(32'h500, 32'd0, "x0 after write");
    endtask

    initial begin
        rst       = 1'b1;
        errors    = 0;
        tests_run = 0;
        n_words   = 0;
        test_alu_ops();
        test_branches();
        test_jumps();
        test_load_store();
        test_x0();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns with tests still running", watchdog_ns);
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== tests/wb_mem_model.sv ====
`timescale 1ns/1ns
`include "rv_config.svh"

module wb_mem_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] adr,
    input  logic [`RV_XLEN-1:0] dat_i,
    output logic [`RV_XLEN-1:0] dat_o,
    output logic                ack
);

    localparam logic [`RV_XLEN-1:0] end_adr = 32'hffff_fffc;   // sw x0, -4(x0)

    logic [31:0]         mem [1024];
    logic [1023:0]       written;     // Store log, one flag per word
    logic [1:0]          delay;
    logic [1:0]          cnt;
    logic                in_cyc;
    logic [`RV_XLEN-1:0] adr0;
    logic [`RV_XLEN-1:0] dat0;
    int                  n_cyc;
    int                  n_ack;
    int                  n_unstable;
    logic                end_seen;
    integer              seed = 32'h0ce8_45d3;

    // Ack once the wait count reaches the drawn delay
    assign ack   = cyc && stb && (cnt == delay);
    assign dat_o = mem[adr[11:2]];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt        <= '0;
            delay      <= '0;
            in_cyc     <= 1'b0;
            written    <= '0;
            n_cyc      <= 0;
            n_ack      <= 0;
            n_unstable <= 0;
            end_seen   <= 1'b0;
        end else if (cyc && stb) begin
            if (!in_cyc) begin
                n_cyc <= n_cyc + 1;   // First cycle of a transfer
                adr0  <= adr;
                dat0  <= dat_i;
            end else if (adr !== adr0 || dat_i !== dat0) begin
                n_unstable <= n_unstable + 1;
            end
            if (ack) begin
                n_ack  <= n_ack + 1;
                cnt    <= '0;
                delay  <= $random(seed);   // 0 to 3 wait cycles for the next one
                in_cyc <= 1'b0;
                if (we) begin
                    mem[adr[11:2]]     <= dat_i;
                    written[adr[11:2]] <= 1'b1;
                    if (adr == end_adr) end_seen <= 1'b1;
                end
            end else begin
                cnt    <= cnt + 2'd1;
                in_cyc <= 1'b1;
            end
        end
    end

endmodule
